// ==== src/enc_pkg.sv ====
/*
 * Shared definitions for the four-channel quadrature encoder interface.
 * Holds channel count and widths, the APB register map, the line-phase
 * and register-select enums, and the structs passed between the
 * decoder, the position counters and the APB register block.
 */

package enc_pkg;

    // ----------------------------------------
    // sizes
    // ----------------------------------------
    localparam int NUM_CH    = 4;                  // encoder channels
    localparam int CNT_W     = 24;                 // position counter width
    localparam int APB_AW    = 8;                  // apb address width
    localparam int APB_DW    = 32;                 // apb data width
    localparam int CH_W      = $clog2(NUM_CH);     // channel index bits

    // ----------------------------------------
    // register map
    // ----------------------------------------
    localparam int CH_STRIDE = 16;                 // bytes per channel block
    localparam int OFS_W     = $clog2(CH_STRIDE);  // offset bits inside a block
    localparam logic [OFS_W-1:0]  OFS_COUNT   = 4'h0;   // status word, read only
    localparam logic [OFS_W-1:0]  OFS_PRELOAD = 4'h4;   // preload, write only
    localparam logic [APB_AW-1:0] ADDR_ENABLE = 8'h40;  // enable bits, r/w

    // line state as {a,b}
    typedef enum logic [1:0] {
        PH_00 = 2'b00,
        PH_01 = 2'b01,
        PH_11 = 2'b11,
        PH_10 = 2'b10
    } quad_phase_e;

    // decoded apb target
    typedef enum logic [1:0] {
        SEL_COUNT,
        SEL_PRELOAD,
        SEL_ENABLE,
        SEL_NONE
    } reg_sel_e;

    // decoder -> counter, one transition per cycle at most
    typedef struct packed {
        logic step;     // exactly one line changed
        logic up;       // forward sequence
        logic illegal;  // both lines changed together
    } enc_step_t;

    // register block -> counter preload
    typedef struct packed {
        logic             load;   // one-cycle strobe
        logic [CNT_W-1:0] value;  // new count
    } enc_load_t;

    // counter -> register block, read back in bits 26..0
    typedef struct packed {
        logic             error;  // sticky illegal transition
        logic             dir;    // direction of last step, 1 = up
        logic             wrap;   // sticky roll-over either way
        logic [CNT_W-1:0] count;
    } enc_status_t;

endpackage

// ==== src/quad_decoder.sv ====
/*
 * Quadrature decoder for one channel.
 * Brings the a/b lines into the clock domain with two flops, keeps the
 * last seen phase and flags a step, its direction, or an illegal jump
 * where both lines moved within one sample.
 */

module quad_decoder (
    input  logic               clk,
    input  logic               reset,
    input  logic               a,
    input  logic               b,
    output enc_pkg::enc_step_t step_out
);
    import enc_pkg::*;

    logic [1:0]  sync_meta;  // first stage, may go metastable
    logic [1:0]  sync_q;     // second stage, safe to use
    quad_phase_e cur_phase;  // phase seen this cycle
    quad_phase_e last_phase; // phase stored at the previous edge
    logic [1:0]  diff;       // which lines changed

    // forward successor of a phase: 00 -> 01 -> 11 -> 10 -> 00
    function automatic quad_phase_e fwd_next(input quad_phase_e ph);
        case (ph)
            PH_00:   return PH_01;
            PH_01:   return PH_11;
            PH_11:   return PH_10;
            default: return PH_00;
        endcase
    endfunction

    // ----------------------------------------
    // two-flop line synchronizer
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        sync_meta <= {a, b};
        sync_q    <= sync_meta;
    end

    assign cur_phase = quad_phase_e'(sync_q);

    // phase follows the lines every cycle
    // during reset too, so nothing steps right after reset releases
    always_ff @(posedge clk)
    begin
        last_phase <= cur_phase;
    end

    // ----------------------------------------
    // transition detect
    // ----------------------------------------
    assign diff = cur_phase ^ last_phase;

    always_comb
    begin
        step_out.step    = diff[1] ^ diff[0];                // one line moved
        step_out.illegal = diff[1] & diff[0];                // both moved, no step
        step_out.up      = (cur_phase == fwd_next(last_phase));
    end

endmodule

// ==== src/position_counter.sv ====
/*
 * Position counter for one encoder channel.
 * 24-bit up/down count driven by decoder steps when the channel is
 * enabled, with preload from the register block, sticky wrap and
 * error flags, and the direction of the most recent step.
 */

module position_counter (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 enable,
    input  enc_pkg::enc_step_t   step_in,
    input  enc_pkg::enc_load_t   load,
    output enc_pkg::enc_status_t status
);
    import enc_pkg::*;

    enc_status_t      status_q;  // count plus flags
    logic [CNT_W-1:0] count_inc; // count + 1, wraps naturally
    logic [CNT_W-1:0] count_dec; // count - 1, wraps naturally
    logic             at_max;    // all ones, next up step wraps
    logic             at_zero;   // next down step wraps

    assign count_inc = status_q.count + 1'b1;
    assign count_dec = status_q.count - 1'b1;
    assign at_max    = &status_q.count;
    assign at_zero   = ~|status_q.count;

    // ----------------------------------------
    // count and flags
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            status_q <= '0;
        end
        else if (load.load)
        begin
            // preload beats any step in the same cycle
            status_q.count <= load.value;
            status_q.wrap  <= 1'b0;
            status_q.error <= 1'b0;   // dir is kept as is
        end
        else if (enable)
        begin
            if (step_in.step)
            begin
                status_q.count <= step_in.up ? count_inc : count_dec;
                status_q.dir   <= step_in.up;
                if ((step_in.up && at_max) || (!step_in.up && at_zero))
                    status_q.wrap <= 1'b1;  // sticky until preload
            end
            if (step_in.illegal)
                status_q.error <= 1'b1;     // sticky until preload
        end
    end

    assign status = status_q;

endmodule

// ==== src/enc_apb_regs.sv ====
/*
 * APB register block for the encoder interface.
 * Decodes the address into a channel and a target register, issues
 * preload strobes to the counters, holds the per-channel enable bits
 * and returns status or enable on reads. No wait states.
 */

module enc_apb_regs (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [enc_pkg::APB_AW-1:0]  paddr,
    input  logic [enc_pkg::APB_DW-1:0]  pwdata,
    output logic [enc_pkg::APB_DW-1:0]  prdata,
    output logic                        pready,
    output logic                        pslverr,
    input  enc_pkg::enc_status_t        status [enc_pkg::NUM_CH],
    output enc_pkg::enc_load_t          load   [enc_pkg::NUM_CH],
    output logic [enc_pkg::NUM_CH-1:0]  enable
);
    import enc_pkg::*;

    logic             access;     // access phase of a transfer
    logic             wr_access;  // access phase, write
    logic             rd_access;  // access phase, read
    logic [CH_W-1:0]  ch;         // addressed channel
    logic [OFS_W-1:0] ofs;        // offset inside channel block
    logic             in_ch_area; // address falls in a channel block
    reg_sel_e         sel;        // decoded target
    logic             bad_access; // unmapped or wrong direction

    assign access    = psel & penable;
    assign wr_access = access & pwrite;
    assign rd_access = access & ~pwrite;

    // ----------------------------------------
    // address decode
    // ----------------------------------------
    assign ch         = paddr[OFS_W +: CH_W];
    assign ofs        = paddr[OFS_W-1:0];
    assign in_ch_area = (paddr < APB_AW'(NUM_CH * CH_STRIDE));

    always_comb
    begin
        sel = SEL_NONE;
        if (paddr == ADDR_ENABLE)
            sel = SEL_ENABLE;
        else if (in_ch_area && ofs == OFS_COUNT)
            sel = SEL_COUNT;
        else if (in_ch_area && ofs == OFS_PRELOAD)
            sel = SEL_PRELOAD;
    end

    // status is read only, preload is write only
    always_comb
    begin
        case (sel)
            SEL_COUNT:   bad_access = pwrite;
            SEL_PRELOAD: bad_access = ~pwrite;
            SEL_ENABLE:  bad_access = 1'b0;
            default:     bad_access = 1'b1;
        endcase
    end

    assign pready  = 1'b1;                   // never stall
    assign pslverr = access & bad_access;    // low outside access cycles

    // ----------------------------------------
    // enable register
    // ----------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
            enable <= '0;
        else if (wr_access && sel == SEL_ENABLE)
            enable <= pwdata[NUM_CH-1:0];
    end

    // preload strobes, valid during the access cycle
    // counter picks them up at the edge that ends it
    always_comb
    begin
        for (int i = 0; i < NUM_CH; i++)
        begin
            load[i].load  = wr_access && (sel == SEL_PRELOAD) && (ch == CH_W'(i));
            load[i].value = pwdata[CNT_W-1:0];
        end
    end

    // ----------------------------------------
    // read mux
    // ----------------------------------------
    always_comb
    begin
        prdata = '0;                         // zero unless a good read
        if (rd_access && !bad_access)
        begin
            case (sel)
                SEL_COUNT:  prdata = APB_DW'(status[ch]);  // upper bits zero
                SEL_ENABLE: prdata = APB_DW'(enable);
                default:    prdata = '0;
            endcase
        end
    end

endmodule

// ==== src/enc_top.sv ====
/*
 * Four-channel quadrature encoder interface, top level.
 * One APB register block shared by all channels, and per channel a
 * line decoder feeding its own position counter.
 */

module enc_top (
    input  logic                        clk,
    input  logic                        reset,
    // apb slave
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [enc_pkg::APB_AW-1:0]  paddr,
    input  logic [enc_pkg::APB_DW-1:0]  pwdata,
    output logic [enc_pkg::APB_DW-1:0]  prdata,
    output logic                        pready,
    output logic                        pslverr,
    // encoder lines, asynchronous
    input  logic [enc_pkg::NUM_CH-1:0]  enc_a,
    input  logic [enc_pkg::NUM_CH-1:0]  enc_b
);
    import enc_pkg::*;

    enc_step_t         step   [NUM_CH];  // decoder -> counter
    enc_load_t         load   [NUM_CH];  // regs -> counter
    enc_status_t       status [NUM_CH];  // counter -> regs
    logic [NUM_CH-1:0] enable;           // per-channel count enable

    // ----------------------------------------
    // register block
    // ----------------------------------------
    enc_apb_regs u_regs (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .status  (status),
        .load    (load),
        .enable  (enable)
    );

    // ----------------------------------------
    // per-channel decode and count
    // ----------------------------------------
    for (genvar i = 0; i < NUM_CH; i++)
    begin : g_ch
        quad_decoder u_dec (
            .clk      (clk),
            .reset    (reset),
            .a        (enc_a[i]),
            .b        (enc_b[i]),
            .step_out (step[i])
        );

        position_counter u_cnt (
            .clk     (clk),
            .reset   (reset),
            .enable  (enable[i]),
            .step_in (step[i]),
            .load    (load[i]),
            .status  (status[i])
        );
    end

endmodule

// ==== verif/enc_tb.sv ====
/*
 * Testbench for the quadrature encoder interface.
 * Moves the encoder lines one step at a time, drives APB transfers,
 * keeps a reference model per channel and checks every readback.
 */

module enc_tb;
    import enc_pkg::*;

    localparam int MAX_CYCLES = 6000;  // ~500 steps at 7 cycles plus bus traffic

    logic clk = 1'b0;
    logic reset, psel, penable, pwrite, pready, pslverr;
    logic [APB_AW-1:0] paddr;
    logic [APB_DW-1:0] pwdata, prdata;
    logic [NUM_CH-1:0] enc_a, enc_b;

    logic [CNT_W-1:0]  exp_count [NUM_CH];               // reference model
    logic [NUM_CH-1:0] exp_wrap, exp_dir, exp_err, exp_en;
    logic [1:0]        line_ph [NUM_CH];                 // {a,b} driven per channel
    int unsigned       seed = 79910;
    int cycles = 0, errors = 0, err_mark = 0, n_pass = 0, n_fail = 0;

    enc_top u_dut (.*);

    always #4 clk = ~clk;

    // ----------------------------------------
    // run limit
    // ----------------------------------------
    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic int unsigned rand_val();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed >> 8;                                // low bits of an lcg are weak
    endfunction

    task automatic flag_error(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        errors++;
    endtask

    // ----------------------------------------
    // apb master
    // ----------------------------------------
    task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                            input logic [APB_DW-1:0] wdata, input logic exp_slverr,
                            output logic [APB_DW-1:0] rdata);
        @(posedge clk);                                  // setup cycle
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;                                 // access cycle
        @(negedge clk);                                  // outputs settled
        rdata = prdata;
        assert (pready === 1'b1) else flag_error("pready low during access cycle");
        assert (pslverr === exp_slverr)
        else flag_error($sformatf("pslverr %b at addr %h", pslverr, addr));
        if (exp_slverr)
        begin
            assert (prdata === '0)
            else flag_error($sformatf("read data %h on bus error at %h", prdata, addr));
        end
        @(posedge clk);                                  // write lands on this edge
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
                             input logic exp_slverr);
        logic [APB_DW-1:0] unused;
        apb_xfer(1'b1, addr, data, exp_slverr, unused);
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, input logic exp_slverr,
                            output logic [APB_DW-1:0] data);
        apb_xfer(1'b0, addr, '0, exp_slverr, data);
    endtask

    task automatic check_all();
        logic [APB_DW-1:0] rd;
        logic [APB_DW-1:0] exp;
        for (int ch = 0; ch < NUM_CH; ch++)
        begin
            exp = {5'b0, exp_err[ch], exp_dir[ch], exp_wrap[ch], exp_count[ch]};
            apb_read(APB_AW'(ch * CH_STRIDE + OFS_COUNT), 1'b0, rd);
            assert (rd === exp)
            else flag_error($sformatf("ch %0d status %h, expected %h", ch, rd, exp));
        end
        apb_read(ADDR_ENABLE, 1'b0, rd);
        assert (rd === APB_DW'(exp_en))
        else flag_error($sformatf("enable reads %h, expected %h", rd, exp_en));
    endtask

    task automatic preload(input int ch, input logic [CNT_W-1:0] val);
        apb_write(APB_AW'(ch * CH_STRIDE + OFS_PRELOAD), APB_DW'(val), 1'b0);
        exp_count[ch] = val;
        exp_wrap[ch]  = 1'b0;
        exp_err[ch]   = 1'b0;                            // dir kept
    endtask

    task automatic set_enable(input logic [NUM_CH-1:0] bits);
        apb_write(ADDR_ENABLE, APB_DW'(bits), 1'b0);
        exp_en = bits;
    endtask

    // ----------------------------------------
    // encoder line model, one move then 6 idle cycles
    // ----------------------------------------
    task automatic move_line(input int ch, input logic up, input logic both);
        logic [1:0] nx;
        if (both)
            nx = ~line_ph[ch];                           // both lines jump
        else if (up)
            nx = {line_ph[ch][0], ~line_ph[ch][1]};      // 00 01 11 10 00
        else
            nx = {~line_ph[ch][0], line_ph[ch][1]};
        @(posedge clk);
        enc_a <= enc_a ^ (NUM_CH'(nx[1] ^ line_ph[ch][1]) << ch);
        enc_b <= enc_b ^ (NUM_CH'(nx[0] ^ line_ph[ch][0]) << ch);
        line_ph[ch] = nx;
        if (exp_en[ch] && both)
            exp_err[ch] = 1'b1;                          // count untouched
        else if (exp_en[ch])
        begin
            if (up ? &exp_count[ch] : ~|exp_count[ch])
                exp_wrap[ch] = 1'b1;
            exp_count[ch] = up ? exp_count[ch] + 1'b1 : exp_count[ch] - 1'b1;
            exp_dir[ch]   = up;
        end
        repeat (6) @(posedge clk);
    endtask

    task automatic end_test(input string name);
        if (errors == err_mark)
        begin
            n_pass++;
            $display("test %-8s ok", name);
        end
        else
        begin
            n_fail++;
            $display("test %-8s %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial
    begin
        logic [APB_DW-1:0] rd;
        int ch;
        for (int i = 0; i < NUM_CH; i++)
        begin
            exp_count[i] = '0;
            line_ph[i]   = 2'b00;
        end
        {exp_wrap, exp_dir, exp_err, exp_en} = '0;
        reset   <= 1'b1;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        enc_a   <= '0;
        enc_b   <= '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        repeat (4) @(posedge clk);

        check_all();                                     // reset values
        set_enable(4'b0101);                             // 1 and 3 stay gated
        for (int i = 0; i < 2 * NUM_CH; i++)
            move_line(i % NUM_CH, 1'b1, 1'b0);
        check_all();
        end_test("reset");

        set_enable('1);
        repeat (4)
        begin
            repeat (1 + rand_val() % 40)
                move_line(rand_val() % NUM_CH, 1'(rand_val()), 1'b0);
            check_all();
        end
        end_test("count");

        preload(1, 24'd1);
        repeat (2) move_line(1, 1'b0, 1'b0);             // down through zero
        check_all();
        preload(1, 24'hFFFFFE);
        repeat (3) move_line(1, 1'b1, 1'b0);             // up through all ones
        check_all();
        repeat (2) move_line(1, 1'(rand_val()), 1'b0);   // wrap stays sticky
        check_all();
        end_test("wrap");

        move_line(0, 1'b1, 1'b0);                        // dir up, kept across preload
        move_line(2, 1'b0, 1'b1);                        // error set before preload
        for (int i = 0; i < NUM_CH; i++)
        begin
            preload(i, CNT_W'(rand_val()));
            check_all();
        end
        end_test("preload");

        ch = rand_val() % NUM_CH;
        move_line(ch, 1'b0, 1'b1);
        check_all();
        repeat (5) move_line(ch, 1'(rand_val()), 1'b0);
        check_all();
        end_test("illegal");

        apb_read(8'h44, 1'b1, rd);                       // unmapped
        apb_read(8'h08, 1'b1, rd);                       // hole in channel block
        apb_write(8'h4C, '0, 1'b1);                      // would clear enables if decoded
        apb_write(8'h10, '1, 1'b1);                      // status is read only
        apb_read(8'h34, 1'b1, rd);                       // preload is write only
        check_all();
        end_test("buserr");

        $display("tests passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0 && errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// ==== quad_enc.f ====
src/enc_pkg.sv
src/quad_decoder.sv
src/position_counter.sv
src/enc_apb_regs.sv
src/enc_top.sv
verif/enc_tb.sv

// ==== Bender.yml ====
package:
  name: quad_enc

sources:
  - src/enc_pkg.sv
  - src/quad_decoder.sv
  - src/position_counter.sv
  - src/enc_apb_regs.sv
  - src/enc_top.sv
  - target: test
    files:
      - verif/enc_tb.sv
